// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := core_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/core_macros.svh ====
// ==============================
// Core-wide widths, reset PC and RV32I opcode field values
// ==============================
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data and address width
`define XLEN 32

// Architectural register count, x0 included
`define NREGS 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Major opcode field, instr[6:0]
// Register-register ALU group
`define OPC_OP 7'b0110011
// Register-immediate ALU group
`define OPC_OPIMM 7'b0010011
// Conditional branch group
`define OPC_BRANCH 7'b1100011

`endif

// ==== logic/core_pkg.sv ====
// ==============================
// Shared enums and pipeline packet structs
// ==============================
`include "core_macros.svh"

package core_pkg;

  // Register index, wide enough for NREGS entries
  typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;

  // ==============================
  // Operation encodings
  // ==============================

  // ALU operations, PASS forwards operand b untouched
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS
  } alu_op_e;

  // Branch kinds resolved in execute
  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE
  } br_op_e;

  // ==============================
  // Pipeline packets
  // ==============================

  // Fetch to decode register (pipe1)
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [31:0]       instr;
  } fetch_pkt_t;

  // Decode to execute register (pipe2)
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  rs1_val;
    logic [`XLEN-1:0]  rs2_val;
    logic [`XLEN-1:0]  imm;
    // Operand b source, 1 picks the immediate
    logic              use_imm;
    alu_op_e           alu_op;
    br_op_e            br_op;
    reg_idx_t          rd;
    logic              we;
    logic              illegal;
  } exec_pkt_t;

  // Branch outcome fed back to fetch and decode
  typedef struct packed {
    logic              taken;
    logic [`XLEN-1:0]  target;
  } redirect_t;

  // Register file write, also the forwarding source
  typedef struct packed {
    logic              en;
    reg_idx_t          rd;
    logic [`XLEN-1:0]  data;
  } wb_t;

  // One record per committed instruction
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    reg_idx_t          rd;
    logic              we;
    logic [`XLEN-1:0]  value;
    logic              illegal;
  } retire_t;

endpackage

// ==== logic/core_top.sv ====
// ==============================
// Three-stage RV32I subset core
// ==============================
`timescale 1ns/1ns
`include "core_macros.svh"

module core_top
  import core_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  // Instruction port, data returns in the same cycle
  output logic [`XLEN-1:0] imem_addr_o,
  input  logic [31:0]      imem_data_i,
  // One record per committed instruction
  output retire_t          retire_o
);

  // Stage-to-stage packets
  fetch_pkt_t fetch_pkt;
  exec_pkt_t  exec_pkt;

  // Feedback from execute
  redirect_t  redirect;
  wb_t        wb;

  // Fetch stage, owns the PC and pipe1
  fetch_unit u_fetch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .redirect_i  (redirect),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .fetch_o     (fetch_pkt)
  );

  // Decode stage with the register file and pipe2
  decode_unit u_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .fetch_i    (fetch_pkt),
    .redirect_i (redirect),
    .wb_i       (wb),
    .exec_o     (exec_pkt)
  );

  // Execute and writeback stage
  execute_unit u_execute (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .exec_i     (exec_pkt),
    .redirect_o (redirect),
    .wb_o       (wb),
    .retire_o   (retire_o)
  );

endmodule

// ==== logic/decode_unit.sv ====
// ==============================
// Instruction decoder, operand read and pipe2
// ==============================
`timescale 1ns/1ns
`include "core_macros.svh"

module decode_unit
  import core_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fetch_pkt_t fetch_i,
  input  redirect_t  redirect_i,
  input  wb_t        wb_i,
  output exec_pkt_t  exec_o
);

  // Instruction fields
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i_type;
  logic [`XLEN-1:0] imm_b_type;

  // Decoded controls
  alu_op_e          alu_op;
  br_op_e           br_op;
  logic             use_imm;
  logic             we;
  logic             illegal;
  reg_idx_t         rd;
  logic [`XLEN-1:0] imm;

  // Operands
  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;

  exec_pkt_t        pipe2_q;

  assign opcode = fetch_i.instr[6:0];
  assign funct3 = fetch_i.instr[14:12];
  assign funct7 = fetch_i.instr[31:25];

  // Sign-extended immediates
  assign imm_i_type = {{20{fetch_i.instr[31]}}, fetch_i.instr[31:20]};
  assign imm_b_type = {{20{fetch_i.instr[31]}}, fetch_i.instr[7], fetch_i.instr[30:25],
                       fetch_i.instr[11:8], 1'b0};

  // ==============================
  // Decoder
  // ==============================
  always_comb begin
    alu_op  = ALU_PASS;
    br_op   = BR_NONE;
    use_imm = 1'b0;
    we      = 1'b0;
    illegal = 1'b0;
    rd      = '0;
    imm     = imm_i_type;
    case (opcode)
      `OPC_OP: begin
        we = 1'b1;
        rd = fetch_i.instr[11:7];
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  alu_op = ALU_ADD;
            3'b100:  alu_op = ALU_XOR;
            3'b110:  alu_op = ALU_OR;
            3'b111:  alu_op = ALU_AND;
            default: illegal = 1'b1;
          endcase
        end else if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
          alu_op = ALU_SUB;
        end else begin
          illegal = 1'b1;
        end
      end
      `OPC_OPIMM: begin
        we      = 1'b1;
        use_imm = 1'b1;
        rd      = fetch_i.instr[11:7];
        // No shifts or compares, so funct3 alone selects
        case (funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      `OPC_BRANCH: begin
        imm = imm_b_type;
        case (funct3)
          3'b000:  br_op = BR_BEQ;
          3'b001:  br_op = BR_BNE;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
    // Unsupported encodings retire as harmless no-ops
    if (illegal) begin
      alu_op = ALU_PASS;
      br_op  = BR_NONE;
      we     = 1'b0;
      rd     = '0;
    end
  end

  // Operand read, bypassed from the write in execute
  reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rs1_i      (fetch_i.instr[19:15]),
    .rs2_i      (fetch_i.instr[24:20]),
    .wb_i       (wb_i),
    .rs1_data_o (rs1_val),
    .rs2_data_o (rs2_val)
  );

  // ==============================
  // pipe2
  // ==============================
  always_ff @(posedge clk_i) begin
    if (!rst_ni || redirect_i.taken) begin
      pipe2_q.valid <= 1'b0;
    end else begin
      pipe2_q <= '{valid: fetch_i.valid, pc: fetch_i.pc, rs1_val: rs1_val, rs2_val: rs2_val,
                   imm: imm, use_imm: use_imm, alu_op: alu_op, br_op: br_op, rd: rd,
                   we: we, illegal: illegal};
    end
  end

  assign exec_o = pipe2_q;

endmodule

// ==== logic/execute_unit.sv ====
// ==============================
// ALU, branch resolution, writeback and retirement record
// ==============================
`timescale 1ns/1ns
`include "core_macros.svh"

module execute_unit
  import core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  exec_pkt_t exec_i,
  output redirect_t redirect_o,
  output wb_t       wb_o,
  output retire_t   retire_o
);

  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_result;
  logic             operands_eq;
  logic             br_taken;
  logic             wr_en;
  retire_t          retire_q;

  // ==============================
  // ALU
  // ==============================
  assign op_b = exec_i.use_imm ? exec_i.imm : exec_i.rs2_val;

  always_comb begin
    case (exec_i.alu_op)
      ALU_ADD:  alu_result = exec_i.rs1_val + op_b;
      ALU_SUB:  alu_result = exec_i.rs1_val - op_b;
      ALU_AND:  alu_result = exec_i.rs1_val & op_b;
      ALU_OR:   alu_result = exec_i.rs1_val | op_b;
      ALU_XOR:  alu_result = exec_i.rs1_val ^ op_b;
      default:  alu_result = op_b;
    endcase
  end

  // ==============================
  // Branch resolution
  // ==============================
  // Always compares rs1 against rs2, never the immediate
  assign operands_eq = (exec_i.rs1_val == exec_i.rs2_val);

  always_comb begin
    case (exec_i.br_op)
      BR_BEQ:  br_taken = operands_eq;
      BR_BNE:  br_taken = !operands_eq;
      default: br_taken = 1'b0;
    endcase
  end

  // Target is PC-relative to the branch itself
  assign redirect_o.taken  = exec_i.valid && br_taken;
  assign redirect_o.target = exec_i.pc + exec_i.imm;

  // ==============================
  // Register writeback
  // ==============================
  // Illegal packets already carry we low from decode
  assign wr_en = exec_i.valid && exec_i.we && !exec_i.illegal && (exec_i.rd != '0);

  assign wb_o.en   = wr_en;
  assign wb_o.rd   = exec_i.rd;
  assign wb_o.data = alu_result;

  // ==============================
  // Retirement record
  // ==============================
  // Registered on the same edge the register file takes the write
  // value reads zero when nothing is written
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      retire_q.valid <= 1'b0;
    end else begin
      retire_q <= '{valid: exec_i.valid, pc: exec_i.pc, rd: exec_i.rd, we: wr_en,
                    value: wr_en ? alu_result : '0, illegal: exec_i.illegal};
    end
  end

  assign retire_o = retire_q;

  // The write port never targets x0
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_o.en |-> (wb_o.rd != '0));

  // Redirect comes only from a valid branch, and decode empties pipe2 behind it
  a_redirect_src: assert property (@(posedge clk_i) disable iff (!rst_ni)
    redirect_o.taken |-> exec_i.valid && (exec_i.br_op != BR_NONE) ##1 !exec_i.valid);

endmodule

// ==== logic/fetch_unit.sv ====
// ==============================
// Program counter, instruction port and pipe1
// ==============================
`timescale 1ns/1ns
`include "core_macros.svh"

module fetch_unit
  import core_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  redirect_t        redirect_i,
  output logic [`XLEN-1:0] imem_addr_o,
  input  logic [31:0]      imem_data_i,
  output fetch_pkt_t       fetch_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_next;
  fetch_pkt_t       pipe1_q;

  // Sequential fetch unless execute resolved a taken branch
  assign pc_next = redirect_i.taken ? redirect_i.target : pc_q + `XLEN'd4;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // Memory answers in the same cycle
  assign imem_addr_o = pc_q;

  // ==============================
  // pipe1
  // ==============================
  // Word fetched this cycle is younger than the branch, so drop it on redirect
  always_ff @(posedge clk_i) begin
    if (!rst_ni || redirect_i.taken) begin
      pipe1_q.valid <= 1'b0;
    end else begin
      pipe1_q <= '{valid: 1'b1, pc: pc_q, instr: imem_data_i};
    end
  end

  assign fetch_o = pipe1_q;

  // Redirect targets and increments must keep the PC on a word boundary
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_q[1:0] == 2'b00);

endmodule

// ==== logic/reg_file.sv ====
// ==============================
// Register file with write-through read bypass
// ==============================
`timescale 1ns/1ns
`include "core_macros.svh"

module reg_file
  import core_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  reg_idx_t         rs1_i,
  input  reg_idx_t         rs2_i,
  input  wb_t              wb_i,
  output logic [`XLEN-1:0] rs1_data_o,
  output logic [`XLEN-1:0] rs2_data_o
);

  logic [`XLEN-1:0] regs_q [`NREGS];

  // Architectural state starts from zero, x0 is never written
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_i.en && (wb_i.rd != '0)) begin
      regs_q[wb_i.rd] <= wb_i.data;
    end
  end

  // Same-cycle write wins over the stored value
  // This is the only forwarding path in the core
  assign rs1_data_o = (rs1_i == '0) ? '0 :
                      (wb_i.en && (wb_i.rd == rs1_i)) ? wb_i.data : regs_q[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 :
                      (wb_i.en && (wb_i.rd == rs2_i)) ? wb_i.data : regs_q[rs2_i];

endmodule

// ==== sim.f ====
+incdir+logic
logic/core_pkg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/core_top.sv
tests/tb_clock.sv
tests/core_tb.sv

// ==== tests/core_tb.sv ====
// ==============================
// Program table, ROM model and retirement checker for the core
// ==============================
`timescale 1ns/1ns
`include "core_macros.svh"

module core_tb
  import core_pkg::*;
();

  localparam int          n_rows     = 22;
  localparam int          rom_words  = 32;
  localparam int          max_cycles = 4 * n_rows + 20;
  // ADDI x0, x0, 0
  localparam logic [31:0] nop_word   = 32'h0000_0013;

  logic             clk;
  logic             rst_n;
  logic [`XLEN-1:0] imem_addr;
  logic [31:0]      imem_data;
  retire_t          retire;

  // Program table with one row per ROM word
  logic [31:0] tbl_instr [n_rows];
  bit          tbl_ret   [n_rows];
  logic [4:0]  tbl_rd    [n_rows];
  bit          tbl_we    [n_rows];
  logic [31:0] tbl_val   [n_rows];
  bit          tbl_ill   [n_rows];
  logic [31:0] rom       [rom_words];

  int n_built    = 0;
  int cycle_cnt  = 0;
  int rel_cnt    = -1;
  int value_errs = 0;
  int other_errs = 0;
  bit first_seen = 0;
  int expect_q[$];

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  core_top u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .retire_o    (retire)
  );

  // Same-cycle ROM padded with no-ops past the program
  assign imem_data = (imem_addr[31:7] == '0) ? rom[imem_addr[6:2]] : nop_word;

  // ==============================
  // RV32I encoders
  // ==============================
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `OPC_OPIMM};
  endfunction

  // Branch offset is bytes from the branch itself
  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  task automatic add_row(input logic [31:0] instr, input bit ret, input logic [4:0] rd,
                         input bit we, input logic [31:0] value, input bit ill);
    tbl_instr[n_built] = instr;
    tbl_ret[n_built]   = ret;
    tbl_rd[n_built]    = rd;
    tbl_we[n_built]    = we;
    tbl_val[n_built]   = value;
    tbl_ill[n_built]   = ill;
    n_built++;
  endtask

  task automatic load_program();
    add_row(enc_i(12'd5, 5'd0, 3'b000, 5'd1), 1, 5'd1, 1, 32'd5, 0);
    add_row(enc_i(12'hffd, 5'd0, 3'b000, 5'd2), 1, 5'd2, 1, 32'hffff_fffd, 0);
    // ALU group on x1 = 5 and x2 = -3 with the first one using the bypass
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1, 5'd3, 1, 32'd2, 0);
    add_row(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1, 5'd4, 1, 32'd8, 0);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 1, 5'd5, 1, 32'd5, 0);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 1, 5'd6, 1, 32'hffff_fffd, 0);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 1, 5'd7, 1, 32'hffff_fff8, 0);
    add_row(enc_i(12'h00f, 5'd7, 3'b100, 5'd8), 1, 5'd8, 1, 32'hffff_fff7, 0);
    // Write to x0 is dropped and x0 then reads back as zero
    add_row(enc_i(12'd7, 5'd1, 3'b000, 5'd0), 1, 5'd0, 0, 32'd0, 0);
    add_row(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd9), 1, 5'd9, 1, 32'd5, 0);
    add_row(enc_i(12'd4, 5'd9, 3'b111, 5'd10), 1, 5'd10, 1, 32'd4, 0);
    // Taken BEQ to row 14 flushes rows 12 and 13
    add_row(enc_b(13'd12, 5'd1, 5'd9, 3'b000), 1, 5'd0, 0, 32'd0, 0);
    add_row(enc_i(12'd1, 5'd0, 3'b000, 5'd11), 0, 5'd0, 0, 32'd0, 0);
    add_row(enc_i(12'd1, 5'd0, 3'b000, 5'd12), 0, 5'd0, 0, 32'd0, 0);
    // Not-taken BNE falls through and the taken BNE skips to row 18
    add_row(enc_b(13'd8, 5'd1, 5'd9, 3'b001), 1, 5'd0, 0, 32'd0, 0);
    add_row(enc_b(13'd12, 5'd1, 5'd2, 3'b001), 1, 5'd0, 0, 32'd0, 0);
    add_row(enc_i(12'd1, 5'd0, 3'b000, 5'd13), 0, 5'd0, 0, 32'd0, 0);
    add_row(enc_i(12'd1, 5'd0, 3'b000, 5'd14), 0, 5'd0, 0, 32'd0, 0);
    // ECALL is outside the subset
    add_row(32'h0000_0073, 1, 5'd0, 0, 32'd0, 1);
    add_row(enc_i(12'h030, 5'd10, 3'b110, 5'd15), 1, 5'd15, 1, 32'h0000_0034, 0);
    add_row(enc_r(7'h20, 5'd8, 5'd15, 3'b000, 5'd16), 1, 5'd16, 1, 32'h0000_003d, 0);
    add_row(enc_r(7'h00, 5'd16, 5'd16, 3'b000, 5'd17), 1, 5'd17, 1, 32'h0000_007a, 0);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errs++;
    $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
  endtask

  // ==============================
  // Retirement checker
  // ==============================
  task automatic check_record(input int row);
    logic [31:0] exp_pc;
    exp_pc = `RESET_PC + 4 * row;
    // First record three cycles after the release edge
    if (!first_seen && rel_cnt != 3) begin
      other_errs++;
      $display("First retirement came %0d cycles after reset release, not 3", rel_cnt);
    end
    first_seen = 1;
    if (retire.pc !== exp_pc) report_mismatch("retire_o.pc", retire.pc, exp_pc);
    if (retire.rd !== tbl_rd[row]) begin
      report_mismatch("retire_o.rd", 32'(retire.rd), 32'(tbl_rd[row]));
    end
    if (retire.we !== tbl_we[row]) begin
      report_mismatch("retire_o.we", 32'(retire.we), 32'(tbl_we[row]));
    end
    if (retire.value !== tbl_val[row]) begin
      report_mismatch("retire_o.value", retire.value, tbl_val[row]);
    end
    if (retire.illegal !== tbl_ill[row]) begin
      report_mismatch("retire_o.illegal", 32'(retire.illegal), 32'(tbl_ill[row]));
    end
  endtask

  initial begin
    int row;
    load_program();
    for (int a = 0; a < rom_words; a++) begin
      rom[a] = (a < n_rows) ? tbl_instr[a] : nop_word;
    end
    for (int r = 0; r < n_rows; r++) begin
      if (tbl_ret[r]) expect_q.push_back(r);
    end
    // Retirement port looked at once per cycle on the falling edge
    while (expect_q.size() != 0 && cycle_cnt < max_cycles) begin
      @(negedge clk);
      cycle_cnt++;
      if (rst_n) rel_cnt++;
      if (!rst_n) begin
        if (retire.valid !== 1'b0) begin
          other_errs++;
          $display("Retirement record valid during reset at %0t", $time);
        end
        // PC sits at the reset address while reset is held
        if (imem_addr !== `RESET_PC) begin
          report_mismatch("imem_addr_o", imem_addr, `RESET_PC);
        end
      end else if (retire.valid === 1'b1) begin
        row = expect_q.pop_front();
        check_record(row);
      end
    end
    if (expect_q.size() != 0) begin
      other_errs++;
      $display("Timeout after %0d cycles with %0d expected records not retired",
               cycle_cnt, expect_q.size());
    end
    $display("Checks done: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/tb_clock.sv ====
// ==============================
// Testbench clock and reset source
// ==============================
`timescale 1ns/1ns

module tb_clock #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock with a 20 ns period by default
  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  // Active-low reset held for reset_cycles rising edges
  initial begin
    rst_no <= 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule
